// File: src/prescaler_consts.svh
/* constants for the DAC prescaler: sample and lane geometry, scale format,
   reset scale, configuration word width and register addresses */
`ifndef PRESCALER_CONSTS_SVH
`define PRESCALER_CONSTS_SVH

// each beat carries LANES signed samples of SAMPLE_WIDTH bits
`define SAMPLE_WIDTH 16
`define LANES 4

// signed scale factor with SCALE_FRAC fraction bits, so it spans -2.0 to just below +2.0
`define SCALE_WIDTH 18
`define SCALE_FRAC 16

// unit gain, the scale the datapath starts with out of reset
`define SCALE_ONE (`SCALE_WIDTH'(1) << `SCALE_FRAC)

// configuration bus word and the saturating clip counter
`define CFG_WIDTH 32
`define CLIP_COUNT_WIDTH 16

// one address bit selects between the two register views
`define ADDR_SCALE 1'b0
`define ADDR_CONTROL 1'b1

`endif

// File: src/prescaler_pkg.sv
/* shared types of the DAC prescaler: samples, beats, scale control,
   the dual-view configuration word and the per-beat clip report */
`include "prescaler_consts.svh"

package prescaler_pkg;

  // one signed sample as it goes to the DAC
  typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

  // all lanes of one stream beat, lane 0 in the low bits
  typedef struct packed {
    sample_t [`LANES-1:0] lane;
  } beat_t;

  // signed fixed-point gain
  typedef logic signed [`SCALE_WIDTH-1:0] scale_t;

  // what the datapath needs from the register block, sampled with every beat
  typedef struct packed {
    scale_t scale;
    logic   bypass;
  } scaler_ctrl_t;

  // the same configuration word read as a scale or as control bits,
  // depending on the address it is written to
  typedef union packed {
    struct packed {
      logic [`CFG_WIDTH-`SCALE_WIDTH-1:0] pad;
      scale_t                             scale;
    } scale_view;
    struct packed {
      logic [`CFG_WIDTH-3:0] pad;
      logic                  clear_clips;
      logic                  bypass;
    } ctrl_view;
  } cfg_word_u;

  // wide enough to count every lane of a beat as clipped
  typedef logic [$clog2(`LANES + 1)-1:0] clip_lanes_t;

  // strobe marks an output transfer, count gives its clipped lanes
  typedef struct packed {
    logic        strobe;
    clip_lanes_t count;
  } clip_report_t;

endpackage

// File: src/scale_regs.sv
/* configuration registers of the DAC prescaler: scale and bypass
   registers, saturating clip counter and the combinational readback */
`timescale 1ns/1ps
`include "prescaler_consts.svh"

module scale_regs (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        cfg_write,
  input  logic                        cfg_addr,
  input  prescaler_pkg::cfg_word_u    cfg_write_data,
  input  prescaler_pkg::clip_report_t clip_report,
  output prescaler_pkg::cfg_word_u    cfg_read_data,
  output prescaler_pkg::scaler_ctrl_t scaler_ctrl,
  output logic [`CLIP_COUNT_WIDTH-1:0] clip_count
);
  import prescaler_pkg::*;

  scale_t scale_reg;
  logic   bypass_reg;

  // decoded write strobes, one per register view
  logic write_scale;
  logic write_ctrl;
  logic clear_clips;

  // one extra bit catches the carry out of the counter
  logic [`CLIP_COUNT_WIDTH:0] count_sum;

  // the address picks which view of the union the write is decoded through
  assign write_scale = cfg_write && (cfg_addr == `ADDR_SCALE);
  assign write_ctrl  = cfg_write && (cfg_addr == `ADDR_CONTROL);

  // clearing is a one-shot command carried in the control word, it is not stored
  assign clear_clips = write_ctrl && cfg_write_data.ctrl_view.clear_clips;

  always_ff @(posedge clk) begin
    if (reset) begin
      scale_reg  <= `SCALE_ONE;
      bypass_reg <= 1'b0;
    end else begin
      if (write_scale) begin
        scale_reg <= cfg_write_data.scale_view.scale;
      end
      if (write_ctrl) begin
        bypass_reg <= cfg_write_data.ctrl_view.bypass;
      end
    end
  end

  // the scaler samples this level together with every beat it accepts
  assign scaler_ctrl.scale  = scale_reg;
  assign scaler_ctrl.bypass = bypass_reg;

  assign count_sum = {1'b0, clip_count} + (`CLIP_COUNT_WIDTH + 1)'(clip_report.count);

  // the counter sticks at all ones rather than wrapping back to a small value
  always_ff @(posedge clk) begin
    if (reset) begin
      clip_count <= '0;
    end else if (clear_clips) begin
      // a clear wins over an increment in the same cycle
      clip_count <= '0;
    end else if (clip_report.strobe) begin
      if (count_sum[`CLIP_COUNT_WIDTH]) begin
        clip_count <= '1;
      end else begin
        clip_count <= count_sum[`CLIP_COUNT_WIDTH-1:0];
      end
    end
  end

  // readback follows the address combinationally, unused bits read as zero
  always_comb begin
    cfg_read_data = '0;
    if (cfg_addr == `ADDR_SCALE) begin
      cfg_read_data.scale_view.scale = scale_reg;
    end else begin
      cfg_read_data.ctrl_view.bypass = bypass_reg;
    end
  end

  // the counter only ever moves up unless it was cleared or reset on the previous edge
  property p_count_monotonic;
    @(posedge clk) disable iff (reset)
      !$past(reset) && !$past(clear_clips) |-> clip_count >= $past(clip_count);
  endproperty

  a_count_monotonic: assert property (p_count_monotonic)
    else $error("clip_count decreased without a clear");

endmodule

// File: src/sample_scaler.sv
/* two-stage DAC sample scaler: per-lane signed multiply, floor, saturation
   and clip flags, with valid/ready stalling across the whole pipeline */
`timescale 1ns/1ps
`include "prescaler_consts.svh"

module sample_scaler (
  input  logic                        clk,
  input  logic                        reset,
  input  prescaler_pkg::scaler_ctrl_t scaler_ctrl,
  input  prescaler_pkg::beat_t        in_beat,
  input  logic                        in_valid,
  output logic                        in_ready,
  output prescaler_pkg::beat_t        out_beat,
  output logic                        out_valid,
  input  logic                        out_ready,
  output prescaler_pkg::clip_report_t clip_report
);
  import prescaler_pkg::*;

  // full product of a sample and the scale, no bits dropped
  localparam int PROD_WIDTH = `SAMPLE_WIDTH + `SCALE_WIDTH;

  typedef logic signed [PROD_WIDTH-1:0] product_t;

  // sample range expressed at product width for the saturation compare
  localparam product_t PROD_MAX = product_t'((2 ** (`SAMPLE_WIDTH - 1)) - 1);
  localparam product_t PROD_MIN = product_t'(-(2 ** (`SAMPLE_WIDTH - 1)));

  // both stages move on the same edge, so one condition stalls everything
  logic advance;

  // stage 1 holds the raw products and the original samples for bypass
  logic     s1_valid;
  logic     s1_bypass;
  beat_t    s1_beat;
  product_t s1_prod [`LANES];

  // stage 2 keeps which lanes were clipped in the beat on the output
  logic [`LANES-1:0] s2_clip;

  // values stage 2 loads on the next advance
  beat_t             next_beat;
  logic [`LANES-1:0] next_clip;

  // stage 2 is either empty or about to hand its beat to the output
  assign advance  = !out_valid || out_ready;
  assign in_ready = advance;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else if (advance) begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

  // payload moves with the valid bits, the control is captured with the beat
  // so a scale change never reaches beats already in flight
  always_ff @(posedge clk) begin
    if (advance) begin
      s1_beat   <= in_beat;
      s1_bypass <= scaler_ctrl.bypass;
      for (int i = 0; i < `LANES; i++) begin
        s1_prod[i] <= product_t'(in_beat.lane[i]) * product_t'(scaler_ctrl.scale);
      end
      out_beat <= next_beat;
      s2_clip  <= next_clip;
    end
  end

  // floor by arithmetic shift, then clamp to the sample range
  always_comb begin
    product_t shifted;
    next_beat = '0;
    next_clip = '0;
    shifted   = '0;
    for (int i = 0; i < `LANES; i++) begin
      // the shift drops the fraction bits and rounds toward minus infinity
      shifted = s1_prod[i] >>> `SCALE_FRAC;
      if (s1_bypass) begin
        next_beat.lane[i] = s1_beat.lane[i];
      end else if (shifted > PROD_MAX) begin
        next_beat.lane[i] = PROD_MAX[`SAMPLE_WIDTH-1:0];
        next_clip[i]      = 1'b1;
      end else if (shifted < PROD_MIN) begin
        next_beat.lane[i] = PROD_MIN[`SAMPLE_WIDTH-1:0];
        next_clip[i]      = 1'b1;
      end else begin
        next_beat.lane[i] = shifted[`SAMPLE_WIDTH-1:0];
      end
    end
  end

  // the report counts clipped lanes only for a beat that actually leaves
  always_comb begin
    clip_report.strobe = out_valid && out_ready;
    clip_report.count  = '0;
    for (int i = 0; i < `LANES; i++) begin
      clip_report.count = clip_report.count + clip_lanes_t'(s2_clip[i]);
    end
  end

  // a stalled output beat stays exactly as it was offered
  property p_beat_stable;
    @(posedge clk) disable iff (reset)
      out_valid && !out_ready |=> $stable(out_beat);
  endproperty

  // once offered, a beat is withdrawn only by a transfer
  property p_valid_held;
    @(posedge clk) disable iff (reset)
      out_valid && !out_ready |=> out_valid;
  endproperty

  a_beat_stable: assert property (p_beat_stable)
    else $error("out_beat changed while stalled");

  a_valid_held: assert property (p_valid_held)
    else $error("out_valid dropped without a transfer");

endmodule

// File: src/dac_prescaler.sv
/* DAC prescaler top: configuration registers beside the scaling pipeline */
`timescale 1ns/1ps
`include "prescaler_consts.svh"

module dac_prescaler (
  input  logic                         clk,
  input  logic                         reset,
  input  prescaler_pkg::beat_t         in_beat,
  input  logic                         in_valid,
  output logic                         in_ready,
  output prescaler_pkg::beat_t         out_beat,
  output logic                         out_valid,
  input  logic                         out_ready,
  input  logic                         cfg_write,
  input  logic                         cfg_addr,
  input  prescaler_pkg::cfg_word_u     cfg_write_data,
  output prescaler_pkg::cfg_word_u     cfg_read_data,
  output logic [`CLIP_COUNT_WIDTH-1:0] clip_count
);
  import prescaler_pkg::*;

  // scale and bypass level going down into the datapath
  scaler_ctrl_t scaler_ctrl;

  // clipped-lane count of each transferred beat coming back up
  clip_report_t clip_report;

  scale_regs scale_regs_i (
    .clk,
    .reset,
    .cfg_write,
    .cfg_addr,
    .cfg_write_data,
    .clip_report,
    .cfg_read_data,
    .scaler_ctrl,
    .clip_count
  );

  sample_scaler sample_scaler_i (
    .clk,
    .reset,
    .scaler_ctrl,
    .in_beat,
    .in_valid,
    .in_ready,
    .out_beat,
    .out_valid,
    .out_ready,
    .clip_report
  );

endmodule

// File: bench/dac_prescaler_tb.sv
/* testbench for the DAC prescaler: stimulus table with expected beats, reference
   model, output scoreboard, register readback and a random back-pressure phase */
`timescale 1ns/1ps
`include "prescaler_consts.svh"

module dac_prescaler_tb;
  import prescaler_pkg::*;

  localparam int TIMEOUT = 200;
  localparam int NUM_VECTORS = 12;
  localparam longint SCALE_UNIT = longint'(1) << `SCALE_FRAC;
  localparam longint SAMPLE_MAX = (longint'(1) << (`SAMPLE_WIDTH - 1)) - 1;
  localparam longint SAMPLE_MIN = -(longint'(1) << (`SAMPLE_WIDTH - 1));

  // one table row, the result is worked out by hand from the scaling rule
  typedef struct packed {
    scale_t scale;
    logic   bypass;
    beat_t  stim;
    beat_t  result;
  } vector_t;

  logic                         clk;
  logic                         reset;
  beat_t                        in_beat;
  logic                         in_valid;
  logic                         in_ready;
  beat_t                        out_beat;
  logic                         out_valid;
  logic                         out_ready;
  logic                         cfg_write;
  logic                         cfg_addr;
  cfg_word_u                    cfg_write_data;
  cfg_word_u                    cfg_read_data;
  logic [`CLIP_COUNT_WIDTH-1:0] clip_count;

  vector_t vectors [NUM_VECTORS];

  // scoreboard state, expected beats and their clip counts in acceptance order
  beat_t  expect_q [$];
  int     clips_q [$];
  beat_t  next_expect;
  int     next_clips;
  int     model_clips;
  int     received;
  int     edge_count;
  int     accept_edge;
  int     deliver_edge;
  logic   last_in_fire;
  logic   random_ready;
  integer seed;

  dac_prescaler dac_prescaler_i (
    .clk,
    .reset,
    .in_beat,
    .in_valid,
    .in_ready,
    .out_beat,
    .out_valid,
    .out_ready,
    .cfg_write,
    .cfg_addr,
    .cfg_write_data,
    .cfg_read_data,
    .clip_count
  );

  always #4 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out at %0t ns while %s", $time, what);
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  endtask

  // floor of sample times scale over 2**16, clamped to the sample range
  function automatic beat_t model_beat(input beat_t stim, input scale_t scale,
                                       input logic bypass, output int clips);
    longint product;
    longint floored;
    beat_t  result;
    clips  = 0;
    result = stim;
    if (!bypass) begin
      for (int i = 0; i < `LANES; i++) begin
        product = longint'(stim.lane[i]) * longint'(scale);
        floored = product / SCALE_UNIT;
        // division truncates toward zero, so negative remainders step down once
        if (product < 0 && (product % SCALE_UNIT) != 0) begin
          floored = floored - 1;
        end
        if (floored > SAMPLE_MAX) begin
          result.lane[i] = sample_t'(SAMPLE_MAX);
          clips++;
        end else if (floored < SAMPLE_MIN) begin
          result.lane[i] = sample_t'(SAMPLE_MIN);
          clips++;
        end else begin
          result.lane[i] = sample_t'(floored);
        end
      end
    end
    return result;
  endfunction

  // one clock of the stream, the handshake is sampled in the quiet low phase
  // and booked once the rising edge has gone by
  task automatic tick();
    logic  in_fire;
    logic  out_fire;
    beat_t seen;
    beat_t want;
    #1;
    in_fire  = in_valid && in_ready;
    out_fire = out_valid && out_ready;
    seen     = out_beat;
    @(negedge clk);
    last_in_fire = in_fire;
    if (in_fire) begin
      expect_q.push_back(next_expect);
      clips_q.push_back(next_clips);
      accept_edge = edge_count;
    end
    if (out_fire) begin
      if (expect_q.size() == 0) begin
        $display("output beat %h arrived at %0t ns with no beat expected", seen, $time);
        $display("SOME TESTS FAILED");
        $fatal(1, "unexpected output beat");
      end
      want = expect_q.pop_front();
      model_clips += clips_q.pop_front();
      check_value("out_beat", 64'(seen), 64'(want));
      deliver_edge = edge_count;
      received++;
    end
    edge_count++;
    if (random_ready) begin
      out_ready = ($random(seed) & 1) != 0;
    end else begin
      out_ready = 1'b1;
    end
  endtask

  task automatic send_beat(input beat_t stim, input beat_t expected, input int clips);
    int waited;
    waited      = 0;
    in_beat     = stim;
    in_valid    = 1'b1;
    next_expect = expected;
    next_clips  = clips;
    tick();
    while (!last_in_fire) begin
      waited++;
      if (waited > TIMEOUT) begin
        report_timeout("waiting for in_ready");
      end
      tick();
    end
    in_valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited   = 0;
    in_valid = 1'b0;
    while (expect_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) begin
        report_timeout("draining the pipeline");
      end
      tick();
    end
  endtask

  task automatic wait_first_output();
    int waited;
    waited = 0;
    while (received == 0) begin
      waited++;
      if (waited > TIMEOUT) begin
        report_timeout("waiting for the first out_valid");
      end
      tick();
    end
  endtask

  task automatic write_cfg(input logic addr, input cfg_word_u data);
    cfg_write      = 1'b1;
    cfg_addr       = addr;
    cfg_write_data = data;
    tick();
    cfg_write      = 1'b0;
    cfg_write_data = '0;
  endtask

  // readback is combinational, so each address gets a full low phase to settle
  task automatic check_readback(input scale_t scale, input logic bypass);
    cfg_addr = `ADDR_SCALE;
    #1;
    check_value("cfg_read_data.scale", 64'(cfg_read_data.scale_view.scale), 64'(scale));
    @(negedge clk);
    cfg_addr = `ADDR_CONTROL;
    #1;
    check_value("cfg_read_data.bypass", 64'(cfg_read_data.ctrl_view.bypass), 64'(bypass));
    @(negedge clk);
  endtask

  task automatic configure(input scale_t scale, input logic bypass, input logic clear);
    cfg_word_u word;
    word = '0;
    word.scale_view.scale = scale;
    write_cfg(`ADDR_SCALE, word);
    word = '0;
    word.ctrl_view.bypass      = bypass;
    word.ctrl_view.clear_clips = clear;
    write_cfg(`ADDR_CONTROL, word);
    check_readback(scale, bypass);
  endtask

  task automatic fill_table();
    // unit gain after reset, the beat must come through untouched
    vectors[0]  = '{scale: 18'h10000, bypass: 1'b0, stim: 64'h7fff_8000_0001_ffff,
                    result: 64'h7fff_8000_0001_ffff};
    // half gain, odd values floor downward on both signs
    vectors[1]  = '{scale: 18'h08000, bypass: 1'b0, stim: 64'h7fff_8000_0003_fffd,
                    result: 64'h3fff_c000_0001_fffe};
    vectors[2]  = '{scale: 18'h08000, bypass: 1'b0, stim: 64'h0064_ff9c_0000_0001,
                    result: 64'h0032_ffce_0000_0000};
    // negative half and three quarters
    vectors[3]  = '{scale: 18'h38000, bypass: 1'b0, stim: 64'h0003_fffd_0064_0001,
                    result: 64'hfffe_0001_ffce_ffff};
    vectors[4]  = '{scale: 18'h0c000, bypass: 1'b0, stim: 64'h0004_0005_fffb_1000,
                    result: 64'h0003_0003_fffc_0c00};
    // just under 2.0, the second row lands on both limits and clips two lanes
    vectors[5]  = '{scale: 18'h1ffff, bypass: 1'b0, stim: 64'h0001_0100_ffff_3fff,
                    result: 64'h0001_01ff_fffe_7ffd};
    vectors[6]  = '{scale: 18'h1ffff, bypass: 1'b0, stim: 64'h4000_c000_7fff_8000,
                    result: 64'h7fff_8000_7fff_8000};
    // minus one on the most negative sample overflows
    vectors[7]  = '{scale: 18'h30000, bypass: 1'b0, stim: 64'h8000_7fff_0001_0000,
                    result: 64'h7fff_8001_ffff_0000};
    vectors[8]  = '{scale: 18'h18000, bypass: 1'b0, stim: 64'h6000_a000_5555_0002,
                    result: 64'h7fff_8000_7fff_0003};
    vectors[9]  = '{scale: 18'h20000, bypass: 1'b0, stim: 64'h0001_ffff_4000_c001,
                    result: 64'hfffe_0002_8000_7ffe};
    // bypass ignores scales that would otherwise clip
    vectors[10] = '{scale: 18'h18000, bypass: 1'b1, stim: 64'h7fff_8000_1234_fedc,
                    result: 64'h7fff_8000_1234_fedc};
    vectors[11] = '{scale: 18'h20000, bypass: 1'b1, stim: 64'h6000_a000_0001_8000,
                    result: 64'h6000_a000_0001_8000};
  endtask

  initial begin
    int     idx;
    int     clips;
    int     gap;
    scale_t cur_scale;
    logic   cur_bypass;
    beat_t  stim;
    beat_t  model_out;
    clk            = 1'b0;
    reset          = 1'b1;
    in_beat        = '0;
    in_valid       = 1'b0;
    out_ready      = 1'b0;
    cfg_write      = 1'b0;
    cfg_addr       = `ADDR_SCALE;
    cfg_write_data = '0;
    seed           = 24662;
    random_ready   = 1'b0;
    last_in_fire   = 1'b0;
    next_expect    = '0;
    next_clips     = 0;
    model_clips    = 0;
    received       = 0;
    edge_count     = 0;
    accept_edge    = 0;
    deliver_edge   = 0;
    fill_table();

    repeat (16) @(negedge clk);
    reset     = 1'b0;
    out_ready = 1'b1;
    @(negedge clk);
    check_readback(`SCALE_ONE, 1'b0);
    check_value("clip_count", 64'(clip_count), 64'd0);

    // each change of scale or bypass starts a new group on an idle stream
    cur_scale  = `SCALE_ONE;
    cur_bypass = 1'b0;
    for (idx = 0; idx < NUM_VECTORS; idx++) begin
      if (vectors[idx].scale !== cur_scale || vectors[idx].bypass !== cur_bypass) begin
        drain();
        check_value("clip_count", 64'(clip_count), 64'(model_clips));
        cur_scale  = vectors[idx].scale;
        cur_bypass = vectors[idx].bypass;
        configure(cur_scale, cur_bypass, 1'b0);
      end
      model_out = model_beat(vectors[idx].stim, cur_scale, cur_bypass, clips);
      check_value("model_beat", 64'(model_out), 64'(vectors[idx].result));
      send_beat(vectors[idx].stim, vectors[idx].result, clips);
      if (idx == 0) begin
        wait_first_output();
        check_value("latency", 64'(deliver_edge - accept_edge), 64'd2);
      end
    end
    drain();
    check_value("clip_count", 64'(clip_count), 64'(model_clips));

    // clear the counter through the control word
    configure(cur_scale, 1'b0, 1'b1);
    model_clips = 0;
    check_value("clip_count", 64'(clip_count), 64'd0);

    // random beats, gaps and back-pressure, the last round in bypass
    random_ready = 1'b1;
    for (int round = 0; round < 4; round++) begin
      cur_scale  = scale_t'($random(seed));
      cur_bypass = (round == 3);
      configure(cur_scale, cur_bypass, 1'b0);
      for (idx = 0; idx < 60; idx++) begin
        gap = $random(seed) & 3;
        repeat (gap) tick();
        stim      = {$random(seed), $random(seed)};
        model_out = model_beat(stim, cur_scale, cur_bypass, clips);
        send_beat(stim, model_out, clips);
      end
      drain();
      check_value("clip_count", 64'(clip_count), 64'(model_clips));
    end

    // with the stream idle and the output open, no further beat may show up
    random_ready = 1'b0;
    repeat (4) tick();
    check_value("out_valid", 64'(out_valid), 64'd0);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: list.f
+incdir+src
src/prescaler_pkg.sv
src/scale_regs.sv
src/sample_scaler.sv
src/dac_prescaler.sv
bench/dac_prescaler_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the DAC prescaler testbench with Verilator and runs it
# the exit status is the simulator's, so a failing run fails this script

set -u

# work from the project root so the paths in list.f resolve
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=dac_prescaler_sim

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found on the PATH"
  exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module dac_prescaler_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi
exit 0
